//--- list.f
common/bt656cap_pkg.sv
bt656cap/bt656cap_decoder.sv
bt656cap/bt656cap_packer.sv
bt656cap/bt656cap_ctlif.sv
verilog/bt656cap.sv
dv/bt656cap_sva.sv
dv/bt656cap_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f list.f --top-module bt656cap_tb \
	-Mdir obj_dir -o simv > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/simv > sim.log 2>&1
grep -q "^Simulation completed successfully$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- dv/bt656cap_tb.sv
/*
 * bt656 capture testbench
 * directed tests over apb, the video byte stream and a
 * memory responder that acks bursts and collects beats
 */
`timescale 1ns/100ps

module bt656cap_tb import bt656cap_pkg::*; ();

	logic sys_clk;
	logic sys_rst;
	vid_byte_t vid;
	logic [11:0] paddr;
	logic psel;
	logic penable;
	logic pwrite;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	mem_cmd_t mem_cmd;
	logic mem_ack;
	mem_beat_t mem_beat;
	logic irq;
	i2c_pins_t i2c;
	logic sda_line;

	// responder control and captured traffic
	int ack_delay;
	logic ack_hold;
	burst_adr_t adr_q[$];
	mem_beat_t beat_q[$];
	logic [31:0] exp_words[$];

	int check_errors;
	int timeout_errors;
	int irq_count;
	int stb_count;
	logic stb_prev;

	bt656cap bt656cap_i (.*);

	initial begin
		sys_clk = 1'b0;
		forever #2 sys_clk = ~sys_clk;
	end

	// irq pulses and stb requests seen on the port
	always @(posedge sys_clk) begin
		if (irq)
			irq_count++;
		if (mem_cmd.stb && !stb_prev)
			stb_count++;
		stb_prev = mem_cmd.stb;
	end

	// ##################################################
	// compare tasks
	// ##################################################

	task automatic check_data(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
			check_errors++;
		end
	endtask

	task automatic check_beat(input string name, input mem_beat_t got, input logic [63:0] exp);
		if (got.data !== exp) begin
			$display("CHECK FAILED %s got %h expected %h", name, got.data, exp);
			check_errors++;
		end
	endtask

	task automatic check_adr(input string name, input burst_adr_t got, input burst_adr_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
			check_errors++;
		end
	endtask

	task automatic report_timeout(input string what);
		$display("timeout while waiting for %s", what);
		timeout_errors++;
	endtask

	task automatic settle(input int cycles);
		repeat (cycles) @(posedge sys_clk);
		#1;
	endtask

	// ##################################################
	// apb master
	// ##################################################

	task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
		int wait_cnt;
		@(posedge sys_clk);
		#1;
		paddr = addr;
		pwdata = data;
		pwrite = 1'b1;
		psel = 1'b1;
		penable = 1'b0;
		@(posedge sys_clk);
		#1;
		penable = 1'b1;
		wait_cnt = 0;
		while (!pready && wait_cnt < 16) begin
			@(posedge sys_clk);
			#1;
			wait_cnt++;
		end
		if (!pready)
			report_timeout("pready on write");
		// write lands on this edge
		@(posedge sys_clk);
		#1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_read(input logic [11:0] addr, output logic [31:0] data, output logic err);
		int wait_cnt;
		@(posedge sys_clk);
		#1;
		paddr = addr;
		pwrite = 1'b0;
		psel = 1'b1;
		penable = 1'b0;
		@(posedge sys_clk);
		#1;
		penable = 1'b1;
		wait_cnt = 0;
		#1;
		while (!pready && wait_cnt < 16) begin
			@(posedge sys_clk);
			#2;
			wait_cnt++;
		end
		if (!pready)
			report_timeout("pready on read");
		data = prdata;
		err = pslverr;
		@(posedge sys_clk);
		#1;
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic read_expect(input string name, input logic [11:0] addr,
		input logic [31:0] exp);
		logic [31:0] data;
		logic err;
		apb_read(addr, data, err);
		check_data(name, data, exp);
		check_data({name, " pslverr"}, 32'(err), 32'd0);
	endtask

	// ##################################################
	// video source
	// ##################################################

	task automatic send_byte(input logic [7:0] b);
		vid.valid = 1'b1;
		vid.data = b;
		@(posedge sys_clk);
		#1;
	endtask

	// FF 00 00 XY, protection bits left at zero
	task automatic send_code(input logic f, input logic v, input logic h);
		send_byte(8'hff);
		send_byte(8'h00);
		send_byte(8'h00);
		send_byte({1'b1, f, v, h, 4'h0});
	endtask

	task automatic send_fill(input int count);
		repeat (count) send_byte(8'h10);
	endtask

	// two blank lines, active lines of random bytes, then a closing EAV with V set
	task automatic send_field(input logic f, input int lines, input int len, input logic record);
		logic [7:0] b;
		logic [31:0] word;
		int idx;
		@(posedge sys_clk);
		#1;
		repeat (2) begin
			send_code(f, 1'b1, 1'b1);
			send_fill(4);
			send_code(f, 1'b1, 1'b0);
			send_fill(8);
		end
		word = '0;
		idx = 0;
		repeat (lines) begin
			send_code(f, 1'b0, 1'b1);
			send_fill(4);
			send_code(f, 1'b0, 1'b0);
			repeat (len) begin
				// FF is reserved for timing codes
				b = 8'($urandom_range(254, 1));
				send_byte(b);
				// reference packing, first byte on top
				word = {word[23:0], b};
				idx++;
				if (idx == 4) begin
					if (record)
						exp_words.push_back(word);
					idx = 0;
				end
			end
		end
		send_code(f, 1'b1, 1'b1);
		send_fill(4);
		vid.valid = 1'b0;
	endtask

	// ##################################################
	// memory responder
	// ##################################################

	task automatic serve_burst();
		int wait_cnt;
		int beat_cnt;
		wait_cnt = 0;
		while (!(mem_cmd.stb && !ack_hold) && wait_cnt < 200) begin
			@(posedge sys_clk);
			#1;
			wait_cnt++;
		end
		if (mem_cmd.stb && !ack_hold) begin
			repeat (ack_delay) begin
				@(posedge sys_clk);
				#1;
			end
			adr_q.push_back(mem_cmd.adr);
			mem_ack = 1'b1;
			@(posedge sys_clk);
			#1;
			mem_ack = 1'b0;
			beat_cnt = 0;
			wait_cnt = 0;
			while (beat_cnt < burst_beats && wait_cnt < 8) begin
				if (mem_beat.valid) begin
					beat_q.push_back(mem_beat);
					beat_cnt++;
				end
				@(posedge sys_clk);
				#1;
				wait_cnt++;
			end
			if (beat_cnt < burst_beats)
				report_timeout("write beats");
		end
	endtask

	initial begin
		repeat (6) @(posedge sys_clk);
		#1;
		forever serve_burst();
	end

	task automatic wait_bursts(input int count);
		int wait_cnt;
		wait_cnt = 0;
		while (adr_q.size() < count && wait_cnt < 2000) begin
			@(posedge sys_clk);
			#1;
			wait_cnt++;
		end
		if (adr_q.size() < count)
			report_timeout("memory bursts");
	endtask

	task automatic clear_capture();
		adr_q.delete();
		beat_q.delete();
		exp_words.delete();
		irq_count = 0;
		stb_count = 0;
	endtask

	// burst k at base plus k, beat j holds words 2j and 2j+1
	task automatic verify_bursts(input burst_adr_t base, input int count);
		logic [63:0] exp;
		check_data("burst count", 32'(adr_q.size()), 32'(count));
		for (int k = 0; k < count && k < adr_q.size(); k++) begin
			check_adr("mem_cmd.adr", adr_q[k], base + burst_adr_t'(k));
			for (int j = 0; j < burst_beats; j++) begin
				exp = {exp_words[8*k + 2*j], exp_words[8*k + 2*j + 1]};
				check_beat("mem_beat.data", beat_q[4*k + j], exp);
			end
		end
	endtask

	// ##################################################
	// directed tests
	// ##################################################

	task automatic test_registers();
		logic [31:0] data;
		logic err;
		read_expect("i2c", reg_i2c, 32'h0);
		read_expect("filter", reg_filter, 32'h0);
		read_expect("base", reg_base, 32'h0);
		read_expect("max", reg_max, 32'h0);
		read_expect("done", reg_done, 32'h0);
		apb_write(reg_filter, 32'hffff_ffff);
		read_expect("filter", reg_filter, 32'h3);
		apb_write(reg_base, 32'hffff_ffff);
		read_expect("base", reg_base, 32'h07ff_ffe0);
		apb_write(reg_max, 32'hffff_ffff);
		read_expect("max", reg_max, 32'h7fff);
		apb_write(reg_done, 32'hffff_ffff);
		read_expect("done", reg_done, 32'h0);
		apb_read(12'h020, data, err);
		check_data("pslverr unmapped", 32'(err), 32'd1);
		apb_write(reg_filter, 32'h0);
		apb_write(reg_base, 32'h0);
		apb_write(reg_max, 32'h0);
	endtask

	task automatic test_i2c();
		apb_write(reg_i2c, 32'h0000_000a);
		check_data("i2c pins", 32'(i2c), 32'h5);
		apb_write(reg_i2c, 32'h0000_0004);
		check_data("i2c pins", 32'(i2c), 32'h2);
		sda_line = 1'b1;
		settle(3);
		read_expect("i2c sda", reg_i2c, 32'h5);
		sda_line = 1'b0;
		settle(3);
		read_expect("i2c sda", reg_i2c, 32'h4);
	endtask

	task automatic test_capture(input burst_adr_t base);
		apb_write(reg_filter, 32'h1);
		apb_write(reg_base, {5'b0, base, 5'b0});
		apb_write(reg_max, 32'd100);
		clear_capture();
		send_field(1'b0, 4, 64, 1'b1);
		wait_bursts(8);
		settle(20);
		check_data("irq count", 32'(irq_count), 32'd1);
		verify_bursts(base, 8);
	endtask

	task automatic test_limit(input burst_adr_t base);
		apb_write(reg_base, {5'b0, base, 5'b0});
		apb_write(reg_max, 32'd3);
		clear_capture();
		send_field(1'b0, 4, 64, 1'b1);
		wait_bursts(3);
		settle(100);
		verify_bursts(base, 3);
		// the next frame start snapshots the count
		send_field(1'b0, 1, 64, 1'b0);
		read_expect("done", reg_done, 32'd3);
		settle(50);
		apb_write(reg_max, 32'd0);
	endtask

	task automatic test_filter(input burst_adr_t base);
		apb_write(reg_filter, 32'h1);
		apb_write(reg_base, {5'b0, base, 5'b0});
		clear_capture();
		fork
			send_field(1'b1, 2, 64, 1'b0);
			begin
				// sample in_frame while the active lines stream
				settle(100);
				read_expect("filter in_frame", reg_filter, 32'h1);
			end
		join
		settle(50);
		check_data("stb count", 32'(stb_count), 32'd0);
		check_data("irq count", 32'(irq_count), 32'd0);
		apb_write(reg_filter, 32'h2);
		clear_capture();
		fork
			send_field(1'b1, 2, 64, 1'b1);
			begin
				settle(100);
				read_expect("filter in_frame", reg_filter, 32'h6);
			end
		join
		wait_bursts(4);
		settle(20);
		verify_bursts(base, 4);
	endtask

	task automatic test_overrun(input burst_adr_t base);
		apb_write(reg_filter, 32'h1);
		apb_write(reg_base, {5'b0, base, 5'b0});
		clear_capture();
		ack_hold = 1'b1;
		// four bursts of data, only two fit in the buffers
		send_field(1'b0, 1, 128, 1'b1);
		read_expect("filter overrun", reg_filter, 32'h9);
		ack_hold = 1'b0;
		wait_bursts(2);
		settle(30);
		verify_bursts(base, 2);
		apb_write(reg_filter, 32'h9);
		read_expect("filter overrun", reg_filter, 32'h1);
	endtask

	initial begin
		check_errors = 0;
		timeout_errors = 0;
		irq_count = 0;
		stb_count = 0;
		stb_prev = 1'b0;
		ack_delay = 2;
		ack_hold = 1'b0;
		sys_rst = 1'b1;
		vid = '0;
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = '0;
		mem_ack = 1'b0;
		sda_line = 1'b0;
		void'($urandom(32'hfe31_6be0));
		repeat (4) @(posedge sys_clk);
		#1;
		sys_rst = 1'b0;

		test_registers();
		test_i2c();
		test_capture(22'h09_1a2b);
		test_limit(22'h00_0400);
		test_filter(22'h12_3450);
		test_overrun(22'h00_0800);

		$display("errors: %0d check, %0d timeout", check_errors, timeout_errors);
		if (check_errors == 0 && timeout_errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- dv/bt656cap_sva.sv
/*
 * bt656 capture assertions
 * memory port handshake, burst limit and apb ready
 */
`timescale 1ns/100ps

module bt656cap_sva import bt656cap_pkg::*; (
	input logic      sys_clk,
	input logic      sys_rst,
	input mem_cmd_t  mem_cmd,
	input logic      mem_ack,
	input mem_beat_t mem_beat,
	input logic      pready,
	input logic      last_burst
);

	// request and address stay put until acked
	stb_hold: assert property (@(posedge sys_clk) disable iff (sys_rst)
		mem_cmd.stb && !mem_ack |=> mem_cmd.stb && $stable(mem_cmd.adr))
		else $error("stb dropped or address moved before ack");

	// four beats right after the ack, then quiet
	beat_run: assert property (@(posedge sys_clk) disable iff (sys_rst)
		mem_cmd.stb && mem_ack |=> mem_beat.valid ##1 mem_beat.valid ##1
		mem_beat.valid ##1 mem_beat.valid ##1 !mem_beat.valid)
		else $error("beat valid not four cycles after ack");

	ready_high: assert property (@(posedge sys_clk) disable iff (sys_rst) pready)
		else $error("pready low");

	// limit reached, no new request
	limit_stb: assert property (@(posedge sys_clk) disable iff (sys_rst)
		$rose(mem_cmd.stb) |-> !last_burst)
		else $error("stb raised while last_burst high");

endmodule

bind bt656cap bt656cap_sva sva_i (
	.sys_clk    (sys_clk),
	.sys_rst    (sys_rst),
	.mem_cmd    (mem_cmd),
	.mem_ack    (mem_ack),
	.mem_beat   (mem_beat),
	.pready     (pready),
	.last_burst (last_burst)
);

//--- verilog/bt656cap.sv
/*
 * bt656 capture top level
 * decoder feeds the burst packer, control interface sets
 * filter, base address and limit over apb
 */
`timescale 1ns/100ps

module bt656cap import bt656cap_pkg::*; (
	input  logic        sys_clk,
	input  logic        sys_rst,
	// video byte stream
	input  vid_byte_t   vid,
	// apb slave
	input  logic [11:0] paddr,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic        pready,
	output logic        pslverr,
	// memory burst write port
	output mem_cmd_t    mem_cmd,
	input  logic        mem_ack,
	output mem_beat_t   mem_beat,
	// misc
	output logic        irq,
	output i2c_pins_t   i2c,
	input  logic        sda_line
);

	pixel_word_t pixel;
	cap_event_t cap_event;
	logic [1:0] field_filter;
	burst_adr_t adr_base;
	logic last_burst;
	logic next_burst;
	logic overrun;

	bt656cap_decoder decoder_i (
		.sys_clk      (sys_clk),
		.sys_rst      (sys_rst),
		.vid          (vid),
		.field_filter (field_filter),
		.pixel        (pixel),
		.cap_event    (cap_event)
	);

	bt656cap_packer packer_i (
		.sys_clk        (sys_clk),
		.sys_rst        (sys_rst),
		.pixel          (pixel),
		.start_of_frame (cap_event.start_of_frame),
		.adr_base       (adr_base),
		.last_burst     (last_burst),
		.mem_ack        (mem_ack),
		.mem_cmd        (mem_cmd),
		.mem_beat       (mem_beat),
		.next_burst     (next_burst),
		.overrun        (overrun)
	);

	bt656cap_ctlif ctlif_i (
		.sys_clk      (sys_clk),
		.sys_rst      (sys_rst),
		.paddr        (paddr),
		.psel         (psel),
		.penable      (penable),
		.pwrite       (pwrite),
		.pwdata       (pwdata),
		.prdata       (prdata),
		.pready       (pready),
		.pslverr      (pslverr),
		.cap_event    (cap_event),
		.next_burst   (next_burst),
		.overrun      (overrun),
		.sda_line     (sda_line),
		.irq          (irq),
		.field_filter (field_filter),
		.adr_base     (adr_base),
		.last_burst   (last_burst),
		.i2c          (i2c)
	);

endmodule

//--- bt656cap/bt656cap_ctlif.sv
/*
 * capture control interface
 * apb registers for i2c pins, field filter, base address and
 * burst limit, plus the per-frame burst counter and irq
 */
`timescale 1ns/100ps

module bt656cap_ctlif import bt656cap_pkg::*; (
	input  logic        sys_clk,
	input  logic        sys_rst,
	input  logic [11:0] paddr,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic        pready,
	output logic        pslverr,
	input  cap_event_t  cap_event,
	input  logic        next_burst,
	input  logic        overrun,
	input  logic        sda_line,
	output logic        irq,
	output logic [1:0]  field_filter,
	output burst_adr_t  adr_base,
	output logic        last_burst,
	output i2c_pins_t   i2c
);

	logic sda_sync1;
	logic sda_sync2;
	logic sdc_q;
	logic sda_oe_q;
	logic sda_o_q;
	logic ovf_flag;
	logic [burst_cnt_w-1:0] max_bursts;
	logic [burst_cnt_w-1:0] done_bursts;
	logic [burst_cnt_w-1:0] burst_counter;
	logic [burst_cnt_w-1:0] cnt_inc;

	logic apb_wr;
	logic reg_hit;

	// ##################################################
	// apb access
	// ##################################################

	// no wait states
	assign pready = 1'b1;
	assign apb_wr = psel && penable && pwrite;
	assign pslverr = psel && penable && !reg_hit;

	// read mux, low base bits and reserved bits read zero
	always_comb begin
		reg_hit = 1'b1;
		prdata = '0;
		case (paddr)
			reg_i2c: prdata = 32'({sdc_q, sda_oe_q, sda_o_q, sda_sync2});
			reg_filter: prdata = 32'({ovf_flag, cap_event.in_frame, field_filter});
			reg_base: prdata = 32'({adr_base, 5'b0});
			reg_max: prdata = 32'(max_bursts);
			reg_done: prdata = 32'(done_bursts);
			default: reg_hit = 1'b0;
		endcase
		if (!psel)
			prdata = '0;
	end

	// writable registers, done is read only
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			sdc_q <= 1'b0;
			sda_oe_q <= 1'b0;
			sda_o_q <= 1'b0;
			field_filter <= 2'b00;
			adr_base <= '0;
			max_bursts <= '0;
		end else if (apb_wr) begin
			case (paddr)
				reg_i2c: begin
					sda_o_q <= pwdata[1];
					sda_oe_q <= pwdata[2];
					sdc_q <= pwdata[3];
				end
				reg_filter: field_filter <= pwdata[1:0];
				reg_base: adr_base <= pwdata[fml_depth-1:5];
				reg_max: max_bursts <= pwdata[burst_cnt_w-1:0];
				default: ;
			endcase
		end
	end

	// sticky overrun, write 1 clears, a new drop wins
	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			ovf_flag <= 1'b0;
		else if (overrun)
			ovf_flag <= 1'b1;
		else if (apb_wr && (paddr == reg_filter) && pwdata[3])
			ovf_flag <= 1'b0;
	end

	// ##################################################
	// i2c pins
	// ##################################################

	// sda comes from the pad, two flop synchronizer
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			sda_sync1 <= 1'b0;
			sda_sync2 <= 1'b0;
		end else begin
			sda_sync1 <= sda_line;
			sda_sync2 <= sda_sync1;
		end
	end

	assign i2c.sdc = sdc_q;
	assign i2c.sda_oe = sda_oe_q;
	assign i2c.sda_o = sda_o_q;

	// ##################################################
	// per-frame burst accounting
	// ##################################################

	assign cnt_inc = burst_counter + 1'b1;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			irq <= 1'b0;
			burst_counter <= '0;
			done_bursts <= '0;
			last_burst <= 1'b0;
		end else begin
			irq <= cap_event.start_of_frame;
			if (cap_event.start_of_frame) begin
				// snapshot what the previous frame wrote
				done_bursts <= burst_counter;
				burst_counter <= '0;
				last_burst <= 1'b0;
			end else if (next_burst) begin
				burst_counter <= cnt_inc;
				// max of zero never matches, capture is unlimited
				last_burst <= (cnt_inc == max_bursts);
			end
		end
	end

endmodule

//--- bt656cap/bt656cap_packer.sv
/*
 * burst packer
 * collects pixel words into two 32-byte buffers and writes
 * each full buffer to memory as a request plus four beats
 */
`timescale 1ns/100ps

module bt656cap_packer import bt656cap_pkg::*; (
	input  logic        sys_clk,
	input  logic        sys_rst,
	input  pixel_word_t pixel,
	input  logic        start_of_frame,
	input  burst_adr_t  adr_base,
	input  logic        last_burst,
	input  logic        mem_ack,
	output mem_cmd_t    mem_cmd,
	output mem_beat_t   mem_beat,
	output logic        next_burst,
	output logic        overrun
);

	localparam int ptr_w = $clog2(burst_words);
	localparam int beat_w = $clog2(burst_beats);

	typedef enum logic [1:0] {
		w_idle,
		w_req,
		w_beat
	} wr_state_t;

	logic [burst_bytes*8-1:0] buf_q [2];
	logic [1:0] full;
	logic wr_sel;
	logic rd_sel;
	logic [ptr_w-1:0] wptr;
	wr_state_t state;
	logic [beat_w-1:0] beat_idx;
	logic [beat_w-1:0] nxt_idx;
	logic [burst_cnt_w-1:0] burst_idx;
	logic stb_q;
	burst_adr_t adr_q;
	logic beat_valid_q;
	logic [63:0] beat_data_q;

	logic word_ok;
	logic fill_now;
	logic discard;
	logic launch;
	logic beat_load;

	// ##################################################
	// fill side
	// ##################################################

	// buffer being filled is full only when both are
	assign overrun = pixel.valid && full[wr_sel];
	assign word_ok = pixel.valid && !full[wr_sel] && !start_of_frame;
	assign fill_now = word_ok && (wptr == ptr_w'(burst_words - 1));

	// ##################################################
	// drain side
	// ##################################################

	// limit reached, drop the buffer instead of writing it
	assign discard = (state == w_idle) && full[rd_sel] && last_burst;
	// the filling word may start the request directly
	assign launch = (state == w_idle) && !last_burst && (full[rd_sel] || fill_now);
	assign next_burst = stb_q && mem_ack;

	assign beat_load = ((state == w_req) && mem_ack) ||
		((state == w_beat) && (beat_idx != beat_w'(burst_beats - 1)));
	assign nxt_idx = (state == w_req) ? '0 : beat_idx + 1'b1;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			full <= 2'b00;
			wr_sel <= 1'b0;
			rd_sel <= 1'b0;
			wptr <= '0;
			state <= w_idle;
			beat_idx <= '0;
			burst_idx <= '0;
			stb_q <= 1'b0;
			beat_valid_q <= 1'b0;
		end else begin
			// partial burst of the previous frame is abandoned
			if (start_of_frame) begin
				wptr <= '0;
			end else if (word_ok) begin
				wptr <= wptr + 1'b1;
				if (fill_now) begin
					full[wr_sel] <= 1'b1;
					wr_sel <= ~wr_sel;
				end
			end

			if (start_of_frame)
				burst_idx <= '0;
			else if (next_burst)
				burst_idx <= burst_idx + 1'b1;

			case (state)
				w_idle: begin
					if (discard) begin
						full[rd_sel] <= 1'b0;
						rd_sel <= ~rd_sel;
					end else if (launch) begin
						stb_q <= 1'b1;
						state <= w_req;
					end
				end
				w_req: begin
					if (mem_ack) begin
						stb_q <= 1'b0;
						beat_valid_q <= 1'b1;
						beat_idx <= '0;
						state <= w_beat;
					end
				end
				default: begin
					if (beat_idx == beat_w'(burst_beats - 1)) begin
						// last beat out, buffer is free again
						beat_valid_q <= 1'b0;
						full[rd_sel] <= 1'b0;
						rd_sel <= ~rd_sel;
						state <= w_idle;
					end else begin
						beat_idx <= beat_idx + 1'b1;
					end
				end
			endcase
		end
	end

	// buffer storage and port payload
	always_ff @(posedge sys_clk) begin
		if (word_ok)
			buf_q[wr_sel][(burst_words - 1 - wptr)*32 +: 32] <= pixel.data;
		if (launch)
			adr_q <= adr_base + burst_adr_t'(burst_idx);
		// first word of a pair lands in the high half
		if (beat_load)
			beat_data_q <= buf_q[rd_sel][(burst_beats - 1 - nxt_idx)*64 +: 64];
	end

	assign mem_cmd.stb = stb_q;
	assign mem_cmd.adr = adr_q;
	assign mem_beat.valid = beat_valid_q;
	assign mem_beat.data = beat_data_q;

endmodule

//--- bt656cap/bt656cap_decoder.sv
/*
 * bt656 stream decoder
 * finds FF 00 00 XY timing codes, tracks F V H, applies the
 * field filter and packs active bytes into 32-bit pixel words
 */
`timescale 1ns/100ps

module bt656cap_decoder import bt656cap_pkg::*; (
	input  logic        sys_clk,
	input  logic        sys_rst,
	input  vid_byte_t   vid,
	input  logic [1:0]  field_filter,
	output pixel_word_t pixel,
	output cap_event_t  cap_event
);

	// preamble matcher states
	typedef enum logic [1:0] {
		s_data,
		s_ff,
		s_zero1,
		s_zero2
	} sync_state_t;

	sync_state_t state;
	logic v_prev;
	logic active;
	logic [1:0] byte_idx;
	logic [23:0] word_sr;
	logic pix_valid;
	logic [31:0] pix_data;
	logic sof_q;
	logic in_frame_q;

	logic code_byte;
	logic code_f;
	logic code_v;
	logic code_h;
	logic code_sof;
	logic code_in_frame;
	logic act_byte;

	// ##################################################
	// timing code decode
	// ##################################################

	// XY byte arrives right after FF 00 00
	assign code_byte = vid.valid && (state == s_zero2);
	assign code_f = vid.data[6];
	assign code_v = vid.data[5];
	assign code_h = vid.data[4];

	// first code out of vertical blank, accepted field only
	assign code_sof = !code_v && v_prev && field_filter[code_f];
	// frame ends at the next code with V set
	assign code_in_frame = code_v ? 1'b0 : (code_sof || in_frame_q);

	// FF never appears inside active video
	assign act_byte = vid.valid && active && (vid.data != 8'hff);

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state <= s_data;
		end else if (vid.valid) begin
			case (state)
				s_data: begin
					if (vid.data == 8'hff)
						state <= s_ff;
				end
				s_ff: begin
					if (vid.data == 8'h00)
						state <= s_zero1;
					else if (vid.data != 8'hff)
						state <= s_data;
				end
				s_zero1: begin
					if (vid.data == 8'h00)
						state <= s_zero2;
					else if (vid.data == 8'hff)
						state <= s_ff;
					else
						state <= s_data;
				end
				// XY consumed, back to plain bytes
				default: state <= s_data;
			endcase
		end
	end

	// frame flags, active window and byte index
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			v_prev <= 1'b0;
			active <= 1'b0;
			byte_idx <= 2'd0;
			sof_q <= 1'b0;
			in_frame_q <= 1'b0;
			pix_valid <= 1'b0;
		end else begin
			sof_q <= 1'b0;
			pix_valid <= 1'b0;
			if (code_byte) begin
				v_prev <= code_v;
				sof_q <= code_sof;
				in_frame_q <= code_in_frame;
				// SAV of a captured line opens the window
				active <= !code_h && code_in_frame;
				if (!code_h)
					byte_idx <= 2'd0;
			end else if (vid.valid && vid.data == 8'hff) begin
				active <= 1'b0;
			end else if (act_byte) begin
				byte_idx <= byte_idx + 2'd1;
				if (byte_idx == 2'd3)
					pix_valid <= 1'b1;
			end
		end
	end

	// ##################################################
	// byte to word packing
	// ##################################################

	always_ff @(posedge sys_clk) begin
		if (act_byte) begin
			word_sr <= {word_sr[15:0], vid.data};
			// fourth byte completes the word, oldest byte on top
			if (byte_idx == 2'd3)
				pix_data <= {word_sr, vid.data};
		end
	end

	assign pixel.valid = pix_valid;
	assign pixel.data = pix_data;
	assign cap_event.in_frame = in_frame_q;
	assign cap_event.start_of_frame = sof_q;

endmodule

//--- common/bt656cap_pkg.sv
/*
 * bt656 capture shared definitions
 * memory geometry, register map and the packed payloads
 * passed between decoder, packer and control interface
 */
package bt656cap_pkg;

	// ##################################################
	// memory geometry
	// ##################################################

	// byte address width of the memory port
	localparam int fml_depth = 27;
	// one burst is 32 bytes, sent as four 64-bit beats
	localparam int burst_bytes = 32;
	localparam int burst_beats = 4;
	// eight pixel words of 32 bits fill one burst
	localparam int burst_words = 8;
	// burst counters, per frame
	localparam int burst_cnt_w = 15;

	// ##################################################
	// apb register map, byte offsets
	// ##################################################

	localparam logic [11:0] reg_i2c = 12'h000;
	localparam logic [11:0] reg_filter = 12'h004;
	localparam logic [11:0] reg_base = 12'h008;
	localparam logic [11:0] reg_max = 12'h00c;
	localparam logic [11:0] reg_done = 12'h010;

	// burst aligned address, low five bits implied zero
	typedef logic [fml_depth-1:5] burst_adr_t;

	// raw bt656 byte with its strobe
	typedef struct packed {
		logic valid;
		logic [7:0] data;
	} vid_byte_t;

	// Cb Y Cr Y, first byte in the top bits
	typedef struct packed {
		logic valid;
		logic [31:0] data;
	} pixel_word_t;

	// frame status from the decoder
	typedef struct packed {
		logic in_frame;
		logic start_of_frame;
	} cap_event_t;

	// burst request, held until ack
	typedef struct packed {
		logic stb;
		burst_adr_t adr;
	} mem_cmd_t;

	// write beat
	typedef struct packed {
		logic valid;
		logic [63:0] data;
	} mem_beat_t;

	// bit-banged i2c outputs toward the video decoder chip
	typedef struct packed {
		logic sdc;
		logic sda_oe;
		logic sda_o;
	} i2c_pins_t;

endpackage
